//--- logic/ctrl_bus_pkg.sv
/*
 * Host bus definitions for the radio control core.
 * Bus geometry, slave window numbers, misc register offsets and the
 * values the misc bank returns for its fixed locations.
 */

package ctrl_bus_pkg;

   // host bus geometry
   localparam int BUS_DW   = 16;
   localparam int BUS_AW   = 11;
   localparam int DECODE_W = 4;   // slave number from adr[10:7]
   localparam int MISC_AW  = 7;   // offset inside a slave window

   // slave windows
   localparam logic [DECODE_W-1:0] SLV_MISC     = 4'd0;
   localparam logic [DECODE_W-1:0] SLV_READBACK = 4'd7;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS = 4'd8;  // double wide, 8 and 9

   //////////////////////////////////////////////////
   // misc register offsets
   localparam logic [MISC_AW-1:0] REG_LEDS        = 7'd0;
   localparam logic [MISC_AW-1:0] REG_CGEN_CTRL   = 7'd4;
   localparam logic [MISC_AW-1:0] REG_CGEN_ST     = 7'd6;   // read only
   localparam logic [MISC_AW-1:0] REG_TEST        = 7'd8;
   localparam logic [MISC_AW-1:0] REG_RX_FRAMELEN = 7'd10;  // read only
   localparam logic [MISC_AW-1:0] REG_TX_FRAMELEN = 7'd12;
   localparam logic [MISC_AW-1:0] REG_XFER_RATE   = 7'd14;
   localparam logic [MISC_AW-1:0] REG_COMPAT      = 7'd16;  // read only

   localparam logic [7:0]        COMPAT_NUM      = 8'd5;
   localparam logic [BUS_DW-1:0] MISC_DEFAULT    = 16'hBEEF;
   localparam logic [1:0]        CGEN_CTRL_RESET = 2'b11;  // sync_b and ref_sel high

endpackage

//--- logic/ctrl_settings_pkg.sv
/*
 * Settings bus definitions for the radio control core.
 * Geometry of the 32-bit setting strobe, the setting register map
 * and the VITA timer constants.
 */

package ctrl_settings_pkg;

   // settings bus geometry
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;
   localparam int SET_RW = 6;   // 64 registers

   //////////////////////////////////////////////////
   // setting register map
   localparam logic [SET_AW-1:0] SR_TIME64        = 8'd42;  // +0 secs, +1 ticks
   localparam logic [SET_AW-1:0] SR_REG_TEST32    = 8'd60;
   localparam logic [SET_AW-1:0] SR_CLEAR_RX_FIFO = 8'd61;
   localparam logic [SET_AW-1:0] SR_CLEAR_TX_FIFO = 8'd62;
   localparam logic [SET_AW-1:0] SR_GLOBAL_RESET  = 8'd63;

   // vita time, seconds over ticks
   localparam logic [31:0] TICKS_PER_SEC = 32'd64000000;
   localparam int          VITA_W        = 64;

   // readback window
   localparam int RB_WORDS = 16;

endpackage

//--- logic/host_bus_decode.sv
/*
 * Host bus decoder. Splits the host address into slave windows,
 * strobes the selected write slave and returns a registered one
 * cycle acknowledge with read data. Unmapped windows never ack.
 */

`timescale 1ns/100ps

module host_bus_decode
  (input  logic                             wb_clk,
   input  logic                             core_rst_i,
   input  logic                             bus_cyc_i,
   input  logic                             bus_stb_i,
   input  logic                             bus_we_i,
   input  logic [ctrl_bus_pkg::BUS_AW-1:0]  bus_adr_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]  misc_rd_dat_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]  rb_rd_dat_i,
   output logic                             bus_ack_o,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]  bus_dat_o,
   output logic                             misc_wr_stb_o,
   output logic                             set_wr_stb_o);

   import ctrl_bus_pkg::*;

   logic [DECODE_W-1:0] slv;
   logic                sel_misc, sel_rb, sel_set;
   logic                accept;
   logic [BUS_DW-1:0]   rd_sel;

   assign slv      = bus_adr_i[BUS_AW-1 -: DECODE_W];
   assign sel_misc = (slv == SLV_MISC);
   assign sel_rb   = (slv == SLV_READBACK);
   assign sel_set  = (slv[DECODE_W-1:1] == SLV_SETTINGS[DECODE_W-1:1]);  // 8 and 9

   // a held request is taken once, the ack cycle blocks a second take
   assign accept = bus_cyc_i & bus_stb_i & ~bus_ack_o & (sel_misc | sel_rb | sel_set);

   assign misc_wr_stb_o = accept & bus_we_i & sel_misc;
   assign set_wr_stb_o  = accept & bus_we_i & sel_set;

   // settings window has nothing to read
   assign rd_sel = sel_misc ? misc_rd_dat_i :
                   sel_rb   ? rb_rd_dat_i   : '0;

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         bus_ack_o <= 1'b0;
      else
         bus_ack_o <= accept;
   end

   always_ff @(posedge wb_clk)
   begin
      if (accept && !bus_we_i)
         bus_dat_o <= rd_sel;   // valid with the ack
   end

endmodule

//--- logic/misc_regs.sv
/*
 * Misc control and status bank in slave window 0.
 * LEDs, clock generator control and status, test register,
 * frame lengths, transfer rate and the compatibility number.
 */

`timescale 1ns/100ps

module misc_regs
  (input  logic                              wb_clk,
   input  logic                              core_rst_i,
   input  logic                              wr_stb_i,
   input  logic [ctrl_bus_pkg::MISC_AW-1:0]  adr_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]   dat_i,
   input  logic                              cgen_st_status_i,
   input  logic                              cgen_st_ld_i,
   input  logic                              cgen_st_refmon_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]   rx_frame_len_i,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]   rd_dat_o,
   output logic [3:0]                        debug_led_o,
   output logic                              cgen_sync_b_o,
   output logic                              cgen_ref_sel_o,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]   tx_frame_len_o,
   output logic [7:0]                        test_rate_o,
   output logic [3:0]                        test_ctrl_o);

   import ctrl_bus_pkg::*;

   logic [BUS_DW-1:0] reg_leds, reg_cgen_ctrl, reg_test, reg_tx_framelen, reg_xfer_rate;

   //////////////////////////////////////////////////
   // write side
   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         reg_leds        <= '0;
         reg_cgen_ctrl   <= {{(BUS_DW-2){1'b0}}, CGEN_CTRL_RESET};
         reg_test        <= '0;
         reg_tx_framelen <= '0;
         reg_xfer_rate   <= '0;
      end
      else if (wr_stb_i)
      begin
         case (adr_i)
            REG_LEDS        : reg_leds        <= dat_i;
            REG_CGEN_CTRL   : reg_cgen_ctrl   <= dat_i;
            REG_TEST        : reg_test        <= dat_i;
            REG_TX_FRAMELEN : reg_tx_framelen <= dat_i;
            REG_XFER_RATE   : reg_xfer_rate   <= dat_i;
            default         : ;   // status offsets ignore writes
         endcase
      end
   end

   assign debug_led_o    = ~reg_leds[3:0];   // leds are active low
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign tx_frame_len_o = reg_tx_framelen;
   assign test_ctrl_o    = reg_xfer_rate[11:8];
   assign test_rate_o    = reg_xfer_rate[7:0];

   //////////////////////////////////////////////////
   // read side, combinational
   always_comb
   begin
      case (adr_i)
         REG_LEDS        : rd_dat_o = reg_leds;
         REG_CGEN_CTRL   : rd_dat_o = reg_cgen_ctrl;
         REG_CGEN_ST     : rd_dat_o = {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST        : rd_dat_o = reg_test;
         REG_RX_FRAMELEN : rd_dat_o = rx_frame_len_i;
         REG_TX_FRAMELEN : rd_dat_o = reg_tx_framelen;
         REG_XFER_RATE   : rd_dat_o = reg_xfer_rate;
         REG_COMPAT      : rd_dat_o = {8'd0, COMPAT_NUM};
         default         : rd_dat_o = MISC_DEFAULT;
      endcase
   end

endmodule

//--- logic/settings_bus_16le.sv
/*
 * 16-bit little-endian settings bus.
 * The low halfword is held until the high halfword arrives, then a
 * single 32-bit setting strobe goes out one cycle later.
 */

`timescale 1ns/100ps

module settings_bus_16le
  (input  logic                                  wb_clk,
   input  logic                                  core_rst_i,
   input  logic                                  wr_stb_i,
   input  logic [7:0]                            adr_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]       dat_i,
   output logic                                  set_stb_o,
   output logic [ctrl_settings_pkg::SET_AW-1:0]  set_addr_o,
   output logic [ctrl_settings_pkg::SET_DW-1:0]  set_data_o);

   import ctrl_settings_pkg::*;

   logic [SET_DW/2-1:0] low_half;
   logic                wr_low, wr_high;

   assign wr_low  = wr_stb_i & ~adr_i[1];
   assign wr_high = wr_stb_i &  adr_i[1];   // completes the word

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half <= dat_i;
      if (wr_high)
      begin
         // word index lives in adr[7:2]
         set_addr_o <= {{(SET_AW-SET_RW){1'b0}}, adr_i[SET_RW+1:2]};
         set_data_o <= {dat_i, low_half};
      end
   end

endmodule

//--- logic/system_settings.sv
/*
 * System setting consumers. FIFO clear pulses, the soft global
 * reset and a 32-bit test register that survives every reset.
 */

`timescale 1ns/100ps

module system_settings
  (input  logic                                  wb_clk,
   input  logic                                  wb_rst,
   input  logic                                  set_stb_i,
   input  logic [ctrl_settings_pkg::SET_AW-1:0]  set_addr_i,
   input  logic [ctrl_settings_pkg::SET_DW-1:0]  set_data_i,
   output logic                                  core_rst_o,
   output logic                                  clear_rx_o,
   output logic                                  clear_tx_o,
   output logic [ctrl_settings_pkg::SET_DW-1:0]  test32_o);

   import ctrl_settings_pkg::*;

   logic glob_rst_pulse;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         clear_rx_o     <= 1'b0;
         clear_tx_o     <= 1'b0;
         glob_rst_pulse <= 1'b0;
      end
      else
      begin
         clear_rx_o     <= set_stb_i && (set_addr_i == SR_CLEAR_RX_FIFO);
         clear_tx_o     <= set_stb_i && (set_addr_i == SR_CLEAR_TX_FIFO);
         glob_rst_pulse <= set_stb_i && (set_addr_i == SR_GLOBAL_RESET);  // data ignored
      end
   end

   // core reset follows board reset or the soft reset pulse
   always_ff @(posedge wb_clk)
      core_rst_o <= wb_rst | glob_rst_pulse;

   // lets the host tell a fresh load from a reset one
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SR_REG_TEST32))
         test32_o <= set_data_i;
   end

endmodule

//--- logic/vita_timer.sv
/*
 * VITA time counter. Seconds over ticks, loaded from two settings,
 * ticks wrap once per second, and the time is copied on each PPS edge.
 */

`timescale 1ns/100ps

module vita_timer
  (input  logic                                  wb_clk,
   input  logic                                  core_rst_i,
   input  logic                                  set_stb_i,
   input  logic [ctrl_settings_pkg::SET_AW-1:0]  set_addr_i,
   input  logic [ctrl_settings_pkg::SET_DW-1:0]  set_data_i,
   input  logic                                  pps_i,
   output logic [ctrl_settings_pkg::VITA_W-1:0]  vita_time_o,
   output logic [ctrl_settings_pkg::VITA_W-1:0]  vita_time_pps_o);

   import ctrl_settings_pkg::*;

   logic [VITA_W/2-1:0] secs_r, ticks_r, secs_hold;
   logic                pps_r, pps_d;
   logic                pps_edge;

   // seconds wait here until the ticks word arrives
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SR_TIME64))
         secs_hold <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         secs_r  <= '0;
         ticks_r <= '0;
      end
      else if (set_stb_i && (set_addr_i == SR_TIME64 + 8'd1))
      begin
         secs_r  <= secs_hold;
         ticks_r <= set_data_i;
      end
      else if (ticks_r == TICKS_PER_SEC - 32'd1)
      begin
         secs_r  <= secs_r + 1'b1;   // one second done
         ticks_r <= '0;
      end
      else
         ticks_r <= ticks_r + 1'b1;
   end

   assign vita_time_o = {secs_r, ticks_r};

   //////////////////////////////////////////////////
   // pps capture
   assign pps_edge = pps_r & ~pps_d;

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         pps_r           <= 1'b0;
         pps_d           <= 1'b0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_r <= pps_i;   // input register
         pps_d <= pps_r;
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

//--- logic/readback_mux_16le.sv
/*
 * Readback mux. Sixteen 32-bit status words, returned to the host
 * as 16-bit halves, low half first.
 */

`timescale 1ns/100ps

module readback_mux_16le
  (input  logic [5:0]                            adr_i,
   input  logic [ctrl_settings_pkg::VITA_W-1:0]  vita_time_i,
   input  logic [ctrl_settings_pkg::VITA_W-1:0]  vita_time_pps_i,
   input  logic [ctrl_settings_pkg::SET_DW-1:0]  test32_i,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]       rd_dat_o);

   import ctrl_settings_pkg::*;

   logic [SET_DW-1:0] words [RB_WORDS];
   logic [SET_DW-1:0] word_sel;

   always_comb
   begin
      for (int i = 0; i < RB_WORDS; i++)
         words[i] = '0;   // unused words read zero
      words[0] = vita_time_i[VITA_W-1:VITA_W/2];
      words[1] = vita_time_i[VITA_W/2-1:0];
      words[2] = vita_time_pps_i[VITA_W-1:VITA_W/2];
      words[3] = vita_time_pps_i[VITA_W/2-1:0];
      words[4] = test32_i;
   end

   assign word_sel = words[adr_i[5:2]];
   assign rd_dat_o = adr_i[1] ? word_sel[SET_DW-1:SET_DW/2] : word_sel[SET_DW/2-1:0];

endmodule

//--- logic/u1e_ctrl_core.sv
/*
 * Control plane of the radio core. Host bus decoder, misc bank,
 * settings bus with its consumers and the readback mux.
 */

`timescale 1ns/100ps

module u1e_ctrl_core
  (input  logic                             wb_clk,
   input  logic                             wb_rst,
   input  logic                             bus_cyc_i,
   input  logic                             bus_stb_i,
   input  logic                             bus_we_i,
   input  logic [ctrl_bus_pkg::BUS_AW-1:0]  bus_adr_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]  bus_dat_i,
   output logic                             bus_ack_o,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]  bus_dat_o,
   input  logic                             cgen_st_status_i,
   input  logic                             cgen_st_ld_i,
   input  logic                             cgen_st_refmon_i,
   input  logic [ctrl_bus_pkg::BUS_DW-1:0]  rx_frame_len_i,
   input  logic                             pps_i,
   output logic [3:0]                       debug_led_o,
   output logic                             cgen_sync_b_o,
   output logic                             cgen_ref_sel_o,
   output logic [ctrl_bus_pkg::BUS_DW-1:0]  tx_frame_len_o,
   output logic [7:0]                       test_rate_o,
   output logic [3:0]                       test_ctrl_o,
   output logic                             clear_rx_o,
   output logic                             clear_tx_o);

   import ctrl_bus_pkg::*;
   import ctrl_settings_pkg::*;

   logic              core_rst;
   logic              misc_wr_stb, set_wr_stb;
   logic [BUS_DW-1:0] misc_rd_dat, rb_rd_dat;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data, test32;
   logic [VITA_W-1:0] vita_time, vita_time_pps;

   //////////////////////////////////////////////////
   // input side
   host_bus_decode host_bus_decode_i
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i), .bus_we_i(bus_we_i), .bus_adr_i(bus_adr_i),
      .misc_rd_dat_i(misc_rd_dat), .rb_rd_dat_i(rb_rd_dat),
      .bus_ack_o(bus_ack_o), .bus_dat_o(bus_dat_o),
      .misc_wr_stb_o(misc_wr_stb), .set_wr_stb_o(set_wr_stb));

   // slave 0
   misc_regs misc_regs_i
     (.wb_clk(wb_clk), .core_rst_i(core_rst), .wr_stb_i(misc_wr_stb),
      .adr_i(bus_adr_i[MISC_AW-1:0]), .dat_i(bus_dat_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .rd_dat_o(misc_rd_dat), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .tx_frame_len_o(tx_frame_len_o), .test_rate_o(test_rate_o), .test_ctrl_o(test_ctrl_o));

   // slaves 8 and 9
   settings_bus_16le settings_bus_16le_i
     (.wb_clk(wb_clk), .core_rst_i(core_rst), .wr_stb_i(set_wr_stb),
      .adr_i(bus_adr_i[SET_AW-1:0]), .dat_i(bus_dat_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   //////////////////////////////////////////////////
   // setting consumers
   system_settings system_settings_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .core_rst_o(core_rst), .clear_rx_o(clear_rx_o), .clear_tx_o(clear_tx_o),
      .test32_o(test32));

   vita_timer vita_timer_i
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   // slave 7, output side
   readback_mux_16le readback_mux_16le_i
     (.adr_i(bus_adr_i[5:0]), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .test32_i(test32), .rd_dat_o(rb_rd_dat));

endmodule

//--- dv/host_bus_asserts.sv
/*
 * Host bus handshake checks, bound into the bus decoder.
 * Single cycle acknowledge, ack only after a request, strobes only on writes.
 */

`timescale 1ns/100ps

module host_bus_asserts
  (input logic wb_clk,
   input logic core_rst_i,
   input logic bus_cyc_i,
   input logic bus_stb_i,
   input logic bus_we_i,
   input logic bus_ack_o,
   input logic misc_wr_stb_o,
   input logic set_wr_stb_o);

   ack_single_cycle: assert property (@(posedge wb_clk) disable iff (core_rst_i)
                                      bus_ack_o |=> !bus_ack_o)
      else $error("bus acknowledge high for two cycles in a row");

   // an ack answers the request seen one edge earlier
   ack_after_request: assert property (@(posedge wb_clk) disable iff (core_rst_i)
                                       bus_ack_o |-> $past(bus_cyc_i && bus_stb_i))
      else $error("bus acknowledge without a request in the previous cycle");

   strobe_on_write: assert property (@(posedge wb_clk) disable iff (core_rst_i)
                                     (misc_wr_stb_o || set_wr_stb_o) |-> bus_we_i)
      else $error("slave write strobe while bus_we_i is low");

endmodule

bind host_bus_decode host_bus_asserts host_bus_asserts_i
  (.wb_clk(wb_clk), .core_rst_i(core_rst_i), .bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i),
   .bus_we_i(bus_we_i), .bus_ack_o(bus_ack_o), .misc_wr_stb_o(misc_wr_stb_o),
   .set_wr_stb_o(set_wr_stb_o));

//--- dv/u1e_ctrl_tb.sv
/*
 * Testbench for the radio control core. LFSR driven host accesses
 * checked against a register model, settings bus, soft reset,
 * FIFO clears, VITA time with PPS capture and unmapped slaves.
 */

`timescale 1ns/100ps

module u1e_ctrl_tb;

   import ctrl_bus_pkg::*;
   import ctrl_settings_pkg::*;

   localparam int N_MISC   = 32;
   localparam int N_T32    = 16;
   localparam int ACC_CYC  = 4;    // upper bound for one bus access
   localparam int ACK_WAIT = 16;
   localparam int LEN_MISC  = (N_MISC * 4 + 12) * ACC_CYC;
   localparam int LEN_T32   = N_T32 * 4 * ACC_CYC;
   localparam int LEN_RST   = 24 * ACC_CYC;
   localparam int LEN_CLEAR = 2 * (2 * ACC_CYC + 8);
   localparam int LEN_TIME  = 16 * ACC_CYC + 110;
   localparam int LEN_UNMAP = 3 * ACC_CYC + 8;
   localparam int TIMEOUT_CYC = 2 * (20 + LEN_MISC + LEN_T32 + LEN_RST + LEN_CLEAR
                                     + LEN_TIME + LEN_UNMAP);
   localparam logic [MISC_AW-1:0] WR_OFFS [5] =
      '{REG_LEDS, REG_CGEN_CTRL, REG_TEST, REG_TX_FRAMELEN, REG_XFER_RATE};

   logic              wb_clk, wb_rst;
   logic              bus_cyc, bus_stb, bus_we, bus_ack;
   logic [BUS_AW-1:0] bus_adr;
   logic [BUS_DW-1:0] bus_wdat, bus_rdat;
   logic              cgen_status, cgen_ld, cgen_refmon, pps;
   logic [15:0]       rx_frame_len, tx_frame_len;
   logic [3:0]        debug_led, test_ctrl;
   logic              cgen_sync_b, cgen_ref_sel, clear_rx, clear_tx;
   logic [7:0]        test_rate;

   logic [31:0] lfsr = 32'h8e8d_0edd;
   int          errs, test_errs, tests_run, tests_failed;
   int          cyc_count = 0;
   string       cur_test;

   // register model
   logic [15:0] m_leds, m_cgen, m_test, m_txfl, m_rate, m_rxfl;
   logic [2:0]  m_st;
   logic [31:0] m_test32;

   u1e_ctrl_core u1e_ctrl_core_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .bus_cyc_i(bus_cyc), .bus_stb_i(bus_stb), .bus_we_i(bus_we), .bus_adr_i(bus_adr),
      .bus_dat_i(bus_wdat), .bus_ack_o(bus_ack), .bus_dat_o(bus_rdat),
      .cgen_st_status_i(cgen_status), .cgen_st_ld_i(cgen_ld), .cgen_st_refmon_i(cgen_refmon),
      .rx_frame_len_i(rx_frame_len), .pps_i(pps),
      .debug_led_o(debug_led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .tx_frame_len_o(tx_frame_len), .test_rate_o(test_rate), .test_ctrl_o(test_ctrl),
      .clear_rx_o(clear_rx), .clear_tx_o(clear_tx));

   initial
   begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
   begin
      cyc_count <= cyc_count + 1;
      if (cyc_count >= TIMEOUT_CYC)
      begin
         $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Test failures found");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // random numbers, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[31]};   // one step per bit
      end
      return r;
   endfunction

   function automatic logic [BUS_AW-1:0] misc_adr(input logic [MISC_AW-1:0] off);
      return {SLV_MISC, off};
   endfunction

   function automatic logic [BUS_AW-1:0] rb_adr(input logic [3:0] word, input logic half);
      return {SLV_READBACK, 1'b0, word, half, 1'b0};
   endfunction

   // expected misc read value
   function automatic logic [15:0] misc_expect(input logic [MISC_AW-1:0] off);
      case (off)
         REG_LEDS        : return m_leds;
         REG_CGEN_CTRL   : return m_cgen;
         REG_CGEN_ST     : return {13'd0, m_st};
         REG_TEST        : return m_test;
         REG_RX_FRAMELEN : return m_rxfl;
         REG_TX_FRAMELEN : return m_txfl;
         REG_XFER_RATE   : return m_rate;
         REG_COMPAT      : return 16'd5;
         default         : return 16'hBEEF;
      endcase
   endfunction

   task automatic model_write(input logic [MISC_AW-1:0] off, input logic [15:0] d);
      case (off)
         REG_LEDS        : m_leds = d;
         REG_CGEN_CTRL   : m_cgen = d;
         REG_TEST        : m_test = d;
         REG_TX_FRAMELEN : m_txfl = d;
         REG_XFER_RATE   : m_rate = d;
         default         : ;
      endcase
   endtask

   task automatic model_reset();
      m_leds = '0;
      m_cgen = 16'h0003;   // sync_b and ref_sel high
      m_test = '0;
      m_txfl = '0;
      m_rate = '0;
   endtask

   //////////////////////////////////////////////////
   // reporting
   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errs++;
      test_errs++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error in %s: %s", cur_test, msg);
      errs++;
      test_errs++;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errs != 0)
         tests_failed++;
      $display("test %s finished with %0d errors", cur_test, test_errs);
      test_errs = 0;
   endtask

   //////////////////////////////////////////////////
   // host bus master
   task automatic bus_access(input logic we, input logic [BUS_AW-1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
      int waited;
      waited = 0;
      rdat = '0;
      @(posedge wb_clk);
      bus_cyc  <= 1'b1;
      bus_stb  <= 1'b1;
      bus_we   <= we;
      bus_adr  <= adr;
      bus_wdat <= wdat;
      @(negedge wb_clk);
      while (!bus_ack && waited < ACK_WAIT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      if (bus_ack)
         rdat = bus_rdat;
      else
         report_failure($sformatf("no acknowledge for address %h", adr));
      @(posedge wb_clk);
      bus_cyc <= 1'b0;
      bus_stb <= 1'b0;
      bus_we  <= 1'b0;
   endtask

   task automatic read_check(input logic [BUS_AW-1:0] adr, input logic [15:0] exp,
                             input string what);
      logic [15:0] rd;
      bus_access(1'b0, adr, 16'h0, rd);
      if (rd !== exp)
         report_mismatch(what, 64'(exp), 64'(rd));
   endtask

   task automatic read_word(input logic [3:0] word, output logic [31:0] val);
      logic [15:0] lo, hi;
      bus_access(1'b0, rb_adr(word, 1'b0), 16'h0, lo);
      bus_access(1'b0, rb_adr(word, 1'b1), 16'h0, hi);
      val = {hi, lo};
   endtask

   // low half first, the high half fires the setting
   task automatic write_setting(input logic [5:0] r, input logic [31:0] d);
      logic [15:0] dummy;
      bus_access(1'b1, {3'b100, r, 1'b0, 1'b0}, d[15:0], dummy);
      bus_access(1'b1, {3'b100, r, 1'b1, 1'b0}, d[31:16], dummy);
   endtask

   task automatic check_outputs(input string what);
      logic [33:0] exp, act;
      @(negedge wb_clk);
      exp = {~m_leds[3:0], m_cgen[1], m_cgen[0], m_txfl, m_rate[7:0], m_rate[11:8]};
      act = {debug_led, cgen_sync_b, cgen_ref_sel, tx_frame_len, test_rate, test_ctrl};
      if (act !== exp)
         report_mismatch(what, 64'(exp), 64'(act));
   endtask

   //////////////////////////////////////////////////
   // test sequence
   initial
   begin
      logic [15:0]        d, rd;
      logic [31:0]        v, s, w, t_before, t_after;
      logic [MISC_AW-1:0] off;
      logic [3:0]         slv;
      int                 idx, n_rx, n_tx, n_ack;

      wb_rst = 1'b1;
      bus_cyc = 1'b0;
      bus_stb = 1'b0;
      bus_we = 1'b0;
      bus_adr = '0;
      bus_wdat = '0;
      {cgen_status, cgen_ld, cgen_refmon} = 3'b000;
      rx_frame_len = '0;
      pps = 1'b0;
      m_st = '0;
      m_rxfl = '0;
      model_reset();
      repeat (16) @(posedge wb_clk);
      wb_rst <= 1'b0;
      repeat (4) @(posedge wb_clk);   // core reset trails by one cycle

      cur_test = "misc_regs";
      for (int i = 0; i < N_MISC; i++)
      begin
         idx = int'(rand_bits(8) % 5);
         d = 16'(rand_bits(16));
         bus_access(1'b1, misc_adr(WR_OFFS[idx]), d, rd);
         model_write(WR_OFFS[idx], d);
         read_check(misc_adr(WR_OFFS[idx]), misc_expect(WR_OFFS[idx]), "register readback");
         check_outputs("register outputs");
         if (i % 4 == 0)
         begin
            m_st = 3'(rand_bits(3));
            m_rxfl = 16'(rand_bits(16));
            @(posedge wb_clk);
            {cgen_status, cgen_ld, cgen_refmon} <= m_st;
            rx_frame_len <= m_rxfl;
            read_check(misc_adr(REG_CGEN_ST), misc_expect(REG_CGEN_ST), "cgen status");
            read_check(misc_adr(REG_RX_FRAMELEN), m_rxfl, "rx frame length");
         end
      end
      read_check(misc_adr(REG_COMPAT), 16'd5, "compat number");
      for (int i = 0; i < 8; i++)
      begin
         off = 7'(rand_bits(7));
         while (off inside {REG_LEDS, REG_CGEN_CTRL, REG_CGEN_ST, REG_TEST, REG_RX_FRAMELEN,
                            REG_TX_FRAMELEN, REG_XFER_RATE, REG_COMPAT})
            off = 7'(rand_bits(7));
         read_check(misc_adr(off), 16'hBEEF, "unlisted offset");
      end
      finish_test();

      cur_test = "test32";
      for (int i = 0; i < N_T32; i++)
      begin
         v = rand_bits(32);
         write_setting(SR_REG_TEST32[5:0], v);
         m_test32 = v;
         read_check(rb_adr(4'd4, 1'b0), v[15:0], "test32 low half");
         read_check(rb_adr(4'd4, 1'b1), v[31:16], "test32 high half");
      end
      finish_test();

      cur_test = "soft_reset";
      bus_access(1'b1, misc_adr(REG_LEDS), 16'h5A5A, rd);
      bus_access(1'b1, misc_adr(REG_XFER_RATE), 16'h0F3C, rd);
      write_setting(SR_TIME64[5:0], rand_bits(32) | 32'd1);   // nonzero seconds
      write_setting(SR_TIME64[5:0] + 6'd1, 32'd1_000_000);
      write_setting(SR_GLOBAL_RESET[5:0], rand_bits(32));
      repeat (4) @(posedge wb_clk);   // core_rst two cycles after set_stb
      model_reset();
      for (int i = 0; i < 5; i++)
         read_check(misc_adr(WR_OFFS[i]), misc_expect(WR_OFFS[i]), "register after reset");
      check_outputs("outputs after reset");
      read_word(4'd0, w);
      if (w !== 32'd0)
         report_mismatch("seconds after reset", 64'd0, 64'(w));
      read_word(4'd1, w);
      if (w >= 32'd64)
         report_failure($sformatf("ticks at %0d long after the reset", w));
      read_check(rb_adr(4'd4, 1'b0), m_test32[15:0], "test32 low half kept");
      read_check(rb_adr(4'd4, 1'b1), m_test32[31:16], "test32 high half kept");
      finish_test();

      cur_test = "clear_fifo";
      for (int k = 0; k < 2; k++)
      begin
         write_setting((k == 0) ? SR_CLEAR_RX_FIFO[5:0] : SR_CLEAR_TX_FIFO[5:0], rand_bits(32));
         n_rx = 0;
         n_tx = 0;
         repeat (8)
         begin
            @(negedge wb_clk);
            n_rx += int'(clear_rx);
            n_tx += int'(clear_tx);
         end
         if (n_rx != ((k == 0) ? 1 : 0))
            report_mismatch("rx clear pulses", 64'((k == 0) ? 1 : 0), 64'(n_rx));
         if (n_tx != ((k == 1) ? 1 : 0))
            report_mismatch("tx clear pulses", 64'((k == 1) ? 1 : 0), 64'(n_tx));
      end
      finish_test();

      cur_test = "vita_time";
      s = rand_bits(32);
      write_setting(SR_TIME64[5:0], s);
      write_setting(SR_TIME64[5:0] + 6'd1, TICKS_PER_SEC - 32'd40);
      repeat (100) @(posedge wb_clk);
      read_word(4'd0, w);
      if (w !== s + 32'd1)
         report_mismatch("seconds after wrap", 64'(s + 32'd1), 64'(w));
      read_word(4'd1, t_before);
      if (t_before >= 32'd100)
         report_failure($sformatf("ticks at %0d, not below 100 after the wrap", t_before));
      @(posedge wb_clk);
      pps <= 1'b1;
      repeat (4) @(posedge wb_clk);   // input register plus edge detect
      pps <= 1'b0;
      read_word(4'd1, t_after);
      read_word(4'd2, w);
      if (w !== s + 32'd1)
         report_mismatch("pps seconds", 64'(s + 32'd1), 64'(w));
      read_word(4'd3, w);
      if (w < t_before || w > t_after)
         report_failure($sformatf("pps ticks %0d outside %0d to %0d", w, t_before, t_after));
      finish_test();

      cur_test = "unmapped";
      slv = 4'(rand_bits(4));
      while (slv == SLV_MISC || slv == SLV_READBACK || slv[3:1] == 3'b100)
         slv = 4'(rand_bits(4));
      @(posedge wb_clk);
      bus_cyc <= 1'b1;
      bus_stb <= 1'b1;
      bus_we  <= 1'(rand_bits(1));
      bus_adr <= {slv, 7'(rand_bits(7))};
      n_ack = 0;
      repeat (8)
      begin
         @(negedge wb_clk);
         n_ack += int'(bus_ack);
      end
      if (n_ack != 0)
         report_failure($sformatf("unmapped slave %0d returned an acknowledge", slv));
      @(posedge wb_clk);
      bus_cyc <= 1'b0;   // master gives up
      bus_stb <= 1'b0;
      bus_we  <= 1'b0;
      read_check(misc_adr(REG_COMPAT), 16'd5, "compat after abort");
      read_check(misc_adr(REG_LEDS), misc_expect(REG_LEDS), "leds after abort");
      finish_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errs);
      if (errs == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- filelist.f
logic/ctrl_bus_pkg.sv
logic/ctrl_settings_pkg.sv
logic/host_bus_decode.sv
logic/misc_regs.sv
logic/settings_bus_16le.sv
logic/system_settings.sv
logic/vita_timer.sv
logic/readback_mux_16le.sv
logic/u1e_ctrl_core.sv
dv/host_bus_asserts.sv
dv/u1e_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the control core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module u1e_ctrl_tb \
      -f filelist.f --Mdir obj_dir; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vu1e_ctrl_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
